//--- common/issue_pkg.sv
//**********************************************************************
// Types and constants shared by the issue stage RTL and its testbench
// Each module imports issue_pkg::* inside its body
//**********************************************************************
package issue_pkg;

    localparam int NUM_FU     = 3;
    localparam int REG_ADDR_W = 5;
    localparam int WORD_W     = 32;
    localparam int AGE_W      = 4;
    localparam int NUM_REGS   = 1 << REG_ADDR_W;

    localparam logic [AGE_W-1:0] AGE_MAX = '1;   // Ages saturate at 15

    // Functional unit codes, one FUST row each
    typedef enum logic [1:0] {
        ALU    = 2'd0,
        LD_ST  = 2'd1,
        BRANCH = 2'd2
    } fu_e;

    typedef logic [1:0] tag_t;                    // Producing unit + 1
    localparam tag_t TAG_READY = 2'd0;

    typedef enum logic [1:0] {
        EMPTY = 2'd0,
        WAIT  = 2'd1,
        EX    = 2'd2
    } fust_state_e;

    typedef struct packed {
        logic                  valid;
        fu_e                   fu;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
    } dispatch_t;

    typedef struct packed {
        logic                  valid;
        fu_e                   fu;
        logic [REG_ADDR_W-1:0] rd;
        logic [WORD_W-1:0]     wdata;
    } wb_t;

    typedef struct packed {
        fust_state_e           state;
        logic [AGE_W-1:0]      age;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        tag_t                  t1;                // Tag of rs1 producer
        tag_t                  t2;                // Tag of rs2 producer
    } fust_row_t;

    typedef fust_row_t [NUM_FU-1:0] fust_rows_t;

    typedef struct packed {
        logic                  valid;
        fu_e                   fu;
        logic [REG_ADDR_W-1:0] rd;
        logic [WORD_W-1:0]     rs1_data;
        logic [WORD_W-1:0]     rs2_data;
    } issue_t;

    // Tag that marks a result still owed by unit fu
    function automatic tag_t fu_tag(fu_e fu);
        return tag_t'(fu) + tag_t'(1);
    endfunction

endpackage

//--- logic/regfile.sv
//**********************************************************************
// Register file with two combinational read ports and write-through
//**********************************************************************
module regfile (
    input  logic                                   CLK,
    input  logic                                   nRST,
    input  issue_pkg::wb_t                         wb,
    input  logic [issue_pkg::REG_ADDR_W-1:0]       rsel1,
    input  logic [issue_pkg::REG_ADDR_W-1:0]       rsel2,
    output logic [issue_pkg::WORD_W-1:0]           rdata1,
    output logic [issue_pkg::WORD_W-1:0]           rdata2
);
    import issue_pkg::*;

    logic [WORD_W-1:0] regs [NUM_REGS];
    logic              wr_en;

    assign wr_en = wb.valid && (wb.rd != '0);   // x0 is never written

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int r = 0; r < NUM_REGS; r++)
                regs[r] <= '0;
        end else if (wr_en) begin
            regs[wb.rd] <= wb.wdata;
        end
    end

    // Bypass the value being written this cycle
    assign rdata1 = (rsel1 == '0)                ? '0 :
                    (wr_en && wb.rd == rsel1)    ? wb.wdata :
                                                   regs[rsel1];
    assign rdata2 = (rsel2 == '0)                ? '0 :
                    (wr_en && wb.rd == rsel2)    ? wb.wdata :
                                                   regs[rsel2];

endmodule

//--- fust/fust_table.sv
//**********************************************************************
// Functional unit status table, one row per scalar unit
// Rows are written by dispatch, moved to EX by issue, freed by writeback
//**********************************************************************
module fust_table (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  row_wr_en,
    input  issue_pkg::fu_e        row_wr_fu,
    input  issue_pkg::fust_row_t  row_wr,
    input  logic                  issue_en,
    input  issue_pkg::fu_e        issue_fu,
    input  issue_pkg::wb_t        wb,
    output issue_pkg::fust_rows_t rows
);
    import issue_pkg::*;

    fust_rows_t rows_q;
    fust_rows_t rows_d;
    tag_t       wb_tag;

    assign wb_tag = fu_tag(wb.fu);

    always_comb begin
        rows_d = rows_q;
        for (int i = 0; i < NUM_FU; i++) begin
            // Waiting rows grow older until the counter saturates
            if (rows_q[i].state == WAIT && rows_q[i].age != AGE_MAX)
                rows_d[i].age = rows_q[i].age + 1'b1;

            // Operand wakeup from the writeback bus
            if (wb.valid && rows_q[i].t1 == wb_tag)
                rows_d[i].t1 = TAG_READY;
            if (wb.valid && rows_q[i].t2 == wb_tag)
                rows_d[i].t2 = TAG_READY;

            if (issue_en && int'(issue_fu) == i && rows_q[i].state == WAIT) begin
                rows_d[i].state = EX;
            end

            // Unit finished, row becomes free again
            if (wb.valid && int'(wb.fu) == i && rows_q[i].state == EX) begin
                rows_d[i].state = EMPTY;
                rows_d[i].age   = '0;
            end

            // Dispatch only targets EMPTY rows
            if (row_wr_en && int'(row_wr_fu) == i)
                rows_d[i] = row_wr;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rows_q <= '0;         // All rows EMPTY
        end else begin
            rows_q <= rows_d;
        end
    end

    assign rows = rows_q;

endmodule

//--- logic/dispatch_ctrl.sv
//**********************************************************************
// Dispatch control, keeps register result status and fills FUST rows
//**********************************************************************
module dispatch_ctrl (
    input  logic                  CLK,
    input  logic                  nRST,
    input  issue_pkg::dispatch_t  dispatch,
    input  issue_pkg::wb_t        wb,
    input  issue_pkg::fust_rows_t rows,
    output logic                  row_wr_en,
    output issue_pkg::fu_e        row_wr_fu,
    output issue_pkg::fust_row_t  row_wr,
    output logic                  dispatch_drop
);
    import issue_pkg::*;

    tag_t status [NUM_REGS];      // Unit that will write each register
    logic fu_ok;
    logic busy;
    logic accept;
    logic wb_clears;
    logic drop_q;

    always_comb begin
        fu_ok = (int'(dispatch.fu) < NUM_FU);
        busy  = 1'b0;
        for (int i = 0; i < NUM_FU; i++) begin
            if (int'(dispatch.fu) == i && rows[i].state != EMPTY)
                busy = 1'b1;
        end
        accept    = dispatch.valid && fu_ok && !busy;
        // Entry is released only while it still names the finishing unit
        wb_clears = wb.valid && (status[wb.rd] == fu_tag(wb.fu));
    end

    // New row goes into the table on the dispatch edge
    always_comb begin
        row_wr       = '0;
        row_wr.state = WAIT;
        row_wr.age   = AGE_W'(1);
        row_wr.rd    = dispatch.rd;
        row_wr.rs1   = dispatch.rs1;
        row_wr.rs2   = dispatch.rs2;
        row_wr.t1    = status[dispatch.rs1];
        row_wr.t2    = status[dispatch.rs2];
        if (dispatch.rs1 == '0 || (wb_clears && wb.rd == dispatch.rs1))
            row_wr.t1 = TAG_READY;  // x0 or result arriving now
        if (dispatch.rs2 == '0 || (wb_clears && wb.rd == dispatch.rs2))
            row_wr.t2 = TAG_READY;
        row_wr_en = accept;
        row_wr_fu = dispatch.fu;
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int r = 0; r < NUM_REGS; r++)
                status[r] <= TAG_READY;
            drop_q <= 1'b0;
        end else begin
            if (wb_clears)
                status[wb.rd] <= TAG_READY;
            if (accept && dispatch.rd != '0)
                status[dispatch.rd] <= fu_tag(dispatch.fu);  // Newest writer wins (WAW)
            drop_q <= dispatch.valid && !accept;
        end
    end

    assign dispatch_drop = drop_q;

endmodule

//--- issue/issue_select.sv
//**********************************************************************
// Oldest-ready issue selection, operand read and issue packet register
// One packet per cycle at most, none while freeze is high
//**********************************************************************
module issue_select (
    input  logic                                   CLK,
    input  logic                                   nRST,
    input  issue_pkg::fust_rows_t                  rows,
    input  logic                                   freeze,
    input  logic [issue_pkg::WORD_W-1:0]           rdata1,
    input  logic [issue_pkg::WORD_W-1:0]           rdata2,
    output logic [issue_pkg::REG_ADDR_W-1:0]       rsel1,
    output logic [issue_pkg::REG_ADDR_W-1:0]       rsel2,
    output logic                                   issue_en,
    output issue_pkg::fu_e                         issue_fu,
    output issue_pkg::issue_t                      issue_out
);
    import issue_pkg::*;

    logic [NUM_FU-1:0]     ready;
    logic                  found;
    fu_e                   sel;
    logic [AGE_W-1:0]      best_age;

    logic                  valid_q;
    fu_e                   fu_q;
    logic [REG_ADDR_W-1:0] rd_q;
    logic [WORD_W-1:0]     rs1_data_q;
    logic [WORD_W-1:0]     rs2_data_q;

    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            ready[i] = (rows[i].state == WAIT) &&
                       (rows[i].t1 == TAG_READY) && (rows[i].t2 == TAG_READY);
        end
    end

    // Strictly greater age replaces, so ties stay with the lower unit
    always_comb begin
        found    = 1'b0;
        sel      = ALU;
        best_age = '0;
        if (!freeze) begin
            for (int i = 0; i < NUM_FU; i++) begin
                if (ready[i] && (!found || rows[i].age > best_age)) begin
                    found    = 1'b1;
                    sel      = fu_e'(i);
                    best_age = rows[i].age;
                end
            end
        end
    end

    assign issue_en = found;
    assign issue_fu = sel;
    assign rsel1    = found ? rows[sel].rs1 : '0;
    assign rsel2    = found ? rows[sel].rs2 : '0;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST)
            valid_q <= 1'b0;
        else
            valid_q <= found;     // Single-cycle strobe
    end

    always_ff @(posedge CLK) begin
        if (found) begin
            fu_q       <= sel;
            rd_q       <= rows[sel].rd;
            rs1_data_q <= rdata1;
            rs2_data_q <= rdata2;
        end
    end

    always_comb begin
        issue_out.valid    = valid_q;
        issue_out.fu       = fu_q;
        issue_out.rd       = rd_q;
        issue_out.rs1_data = rs1_data_q;
        issue_out.rs2_data = rs2_data_q;
    end

endmodule

//--- logic/issue_stage.sv
//**********************************************************************
// Issue stage top, links dispatch, FUST, selector and register file
//**********************************************************************
module issue_stage (
    input  logic                  CLK,
    input  logic                  nRST,
    input  issue_pkg::dispatch_t  dispatch,
    input  issue_pkg::wb_t        wb,
    input  logic                  freeze,
    output issue_pkg::issue_t     issue_out,
    output logic                  dispatch_drop
);
    import issue_pkg::*;

    logic                  row_wr_en;
    fu_e                   row_wr_fu;
    fust_row_t             row_wr;
    fust_rows_t            rows;
    logic                  issue_en;
    fu_e                   issue_fu;
    logic [REG_ADDR_W-1:0] rsel1;
    logic [REG_ADDR_W-1:0] rsel2;
    logic [WORD_W-1:0]     rdata1;
    logic [WORD_W-1:0]     rdata2;

    dispatch_ctrl dispatch_ctrl_inst (
        .CLK           (CLK),
        .nRST          (nRST),
        .dispatch      (dispatch),
        .wb            (wb),
        .rows          (rows),
        .row_wr_en     (row_wr_en),
        .row_wr_fu     (row_wr_fu),
        .row_wr        (row_wr),
        .dispatch_drop (dispatch_drop)
    );

    fust_table fust_table_inst (
        .CLK       (CLK),
        .nRST      (nRST),
        .row_wr_en (row_wr_en),
        .row_wr_fu (row_wr_fu),
        .row_wr    (row_wr),
        .issue_en  (issue_en),
        .issue_fu  (issue_fu),
        .wb        (wb),
        .rows      (rows)
    );

    issue_select issue_select_inst (
        .CLK       (CLK),
        .nRST      (nRST),
        .rows      (rows),
        .freeze    (freeze),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .rsel1     (rsel1),
        .rsel2     (rsel2),
        .issue_en  (issue_en),
        .issue_fu  (issue_fu),
        .issue_out (issue_out)
    );

    regfile regfile_inst (
        .CLK    (CLK),
        .nRST   (nRST),
        .wb     (wb),
        .rsel1  (rsel1),
        .rsel2  (rsel2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

endmodule

//--- test/issue_stage_properties.sv
//**********************************************************************
// Concurrent checks on issue and FUST behavior, bound into issue_stage
//**********************************************************************
module issue_stage_properties (
    input logic                  CLK,
    input logic                  nRST,
    input logic                  freeze,
    input logic                  issue_en,
    input issue_pkg::fu_e        issue_fu,
    input issue_pkg::issue_t     issue_out,
    input issue_pkg::wb_t        wb,
    input issue_pkg::fust_rows_t rows
);
    timeunit 1ns;
    timeprecision 1ps;
    import issue_pkg::*;

    // An issued row is in EX next cycle, so the same unit cannot win again
    a_no_back_to_back: assert property (@(posedge CLK) disable iff (!nRST)
        issue_en |=> !(issue_en && issue_fu == $past(issue_fu)))
        else $error("Unit selected on two consecutive cycles");

    a_freeze_no_packet: assert property (@(posedge CLK) disable iff (!nRST)
        freeze |=> !issue_out.valid)
        else $error("Issue packet produced during freeze");

    for (genvar i = 0; i < NUM_FU; i++) begin : g_ex_hold
        a_ex_until_wb: assert property (@(posedge CLK) disable iff (!nRST)
            (rows[i].state == EX && !(wb.valid && int'(wb.fu) == i))
                |=> rows[i].state == EX)
            else $error("Row %0d left EX without its writeback", i);
    end

endmodule

bind issue_stage issue_stage_properties issue_stage_properties_inst (
    .CLK       (CLK),
    .nRST      (nRST),
    .freeze    (freeze),
    .issue_en  (issue_en),
    .issue_fu  (issue_fu),
    .issue_out (issue_out),
    .wb        (wb),
    .rows      (rows)
);

//--- test/issue_stage_tb.sv
//**********************************************************************
// Testbench for the issue stage, directed cases then a random phase
//**********************************************************************
module issue_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import issue_pkg::*;

    logic      CLK;
    logic      nRST;
    dispatch_t dispatch;
    wb_t       wb;
    logic      freeze;
    issue_t    issue_out;
    logic      dispatch_drop;

    // Reference model state
    logic [WORD_W-1:0] m_regs [NUM_REGS];
    tag_t              m_status [NUM_REGS];
    fust_rows_t        m_rows;
    issue_t            exp_issue;
    logic              exp_drop;

    int errors;
    int dut_issues;
    int exp_issues;
    int seed;

    issue_stage issue_stage_inst (
        .CLK           (CLK),
        .nRST          (nRST),
        .dispatch      (dispatch),
        .wb            (wb),
        .freeze        (freeze),
        .issue_out     (issue_out),
        .dispatch_drop (dispatch_drop)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    function automatic logic [WORD_W-1:0] read_reg(input logic [REG_ADDR_W-1:0] r, input wb_t w);
        if (r == '0)
            return '0;
        if (w.valid && w.rd == r)
            return w.wdata;               // Value written this cycle
        return m_regs[r];
    endfunction

    // Packet the DUT should register at the coming edge
    function automatic issue_t expected_issue(input logic frz, input wb_t w);
        issue_t           p;
        logic             found;
        logic [AGE_W-1:0] best;
        int               sel;
        p     = '0;
        found = 1'b0;
        best  = '0;
        sel   = 0;
        for (int i = 0; i < NUM_FU; i++) begin
            if (!frz && m_rows[i].state == WAIT && m_rows[i].t1 == 2'd0 &&
                m_rows[i].t2 == 2'd0 && (!found || m_rows[i].age > best)) begin
                found = 1'b1;
                best  = m_rows[i].age;
                sel   = i;
            end
        end
        if (found) begin
            p.valid    = 1'b1;
            p.fu       = fu_e'(sel);
            p.rd       = m_rows[sel].rd;
            p.rs1_data = read_reg(m_rows[sel].rs1, w);
            p.rs2_data = read_reg(m_rows[sel].rs2, w);
        end
        return p;
    endfunction

    // True while any model row still holds an instruction
    function automatic logic rows_busy();
        logic busy;
        busy = 1'b0;
        for (int i = 0; i < NUM_FU; i++) begin
            if (m_rows[i].state != EMPTY)
                busy = 1'b1;
        end
        return busy;
    endfunction

    always @(posedge CLK or negedge nRST) begin : model
        fust_rows_t nxt;
        issue_t     pkt;
        logic       accept;
        logic       clears;
        tag_t       wtag;
        int         f;
        if (!nRST) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                m_regs[r]   = '0;
                m_status[r] = 2'd0;
            end
            m_rows    = '0;
            exp_issue = '0;
            exp_drop  = 1'b0;
        end else begin
            pkt    = expected_issue(freeze, wb);
            f      = int'(dispatch.fu);
            accept = dispatch.valid && f < NUM_FU && m_rows[f].state == EMPTY;
            wtag   = tag_t'(int'(wb.fu) + 1);
            clears = wb.valid && m_status[wb.rd] == wtag;
            nxt    = m_rows;
            for (int i = 0; i < NUM_FU; i++) begin
                if (m_rows[i].state == WAIT && m_rows[i].age != 4'd15)
                    nxt[i].age = m_rows[i].age + 4'd1;
                if (wb.valid && m_rows[i].t1 == wtag)
                    nxt[i].t1 = 2'd0;
                if (wb.valid && m_rows[i].t2 == wtag)
                    nxt[i].t2 = 2'd0;
                if (pkt.valid && int'(pkt.fu) == i)
                    nxt[i].state = EX;
                if (wb.valid && int'(wb.fu) == i && m_rows[i].state == EX) begin
                    nxt[i].state = EMPTY;
                    nxt[i].age   = '0;
                end
            end
            if (accept) begin
                nxt[f].state = WAIT;
                nxt[f].age   = 4'd1;
                nxt[f].rd    = dispatch.rd;
                nxt[f].rs1   = dispatch.rs1;
                nxt[f].rs2   = dispatch.rs2;
                nxt[f].t1    = (dispatch.rs1 == '0 || (clears && wb.rd == dispatch.rs1)) ?
                               2'd0 : m_status[dispatch.rs1];
                nxt[f].t2    = (dispatch.rs2 == '0 || (clears && wb.rd == dispatch.rs2)) ?
                               2'd0 : m_status[dispatch.rs2];
            end
            if (clears)
                m_status[wb.rd] = 2'd0;
            if (accept && dispatch.rd != '0)
                m_status[dispatch.rd] = tag_t'(f + 1);
            if (wb.valid && wb.rd != '0)
                m_regs[wb.rd] = wb.wdata;
            m_rows    = nxt;
            exp_issue = pkt;
            exp_drop  = dispatch.valid && !accept;
            if (pkt.valid)
                exp_issues++;
        end
    end

    // Compare DUT outputs with the model, mid-cycle where they are stable
    always @(negedge CLK) begin
        if (nRST) begin
            if (issue_out.valid === 1'b1)
                dut_issues++;
            if (issue_out.valid !== exp_issue.valid) begin
                $display("Fail issue_out.valid got %h expected %h",
                         issue_out.valid, exp_issue.valid);
                errors++;
            end else if (exp_issue.valid) begin
                if (issue_out.fu !== exp_issue.fu) begin
                    $display("Fail issue_out.fu got %h expected %h", issue_out.fu, exp_issue.fu);
                    errors++;
                end
                if (issue_out.rd !== exp_issue.rd) begin
                    $display("Fail issue_out.rd got %h expected %h", issue_out.rd, exp_issue.rd);
                    errors++;
                end
                if (issue_out.rs1_data !== exp_issue.rs1_data) begin
                    $display("Fail issue_out.rs1_data got %h expected %h",
                             issue_out.rs1_data, exp_issue.rs1_data);
                    errors++;
                end
                if (issue_out.rs2_data !== exp_issue.rs2_data) begin
                    $display("Fail issue_out.rs2_data got %h expected %h",
                             issue_out.rs2_data, exp_issue.rs2_data);
                    errors++;
                end
            end
            if (dispatch_drop !== exp_drop) begin
                $display("Fail dispatch_drop got %h expected %h", dispatch_drop, exp_drop);
                errors++;
            end
        end
    end

    task automatic do_dispatch(input fu_e fu, input int rd, input int rs1, input int rs2);
        @(negedge CLK);
        dispatch.valid = 1'b1;
        dispatch.fu    = fu;
        dispatch.rd    = rd[4:0];
        dispatch.rs1   = rs1[4:0];
        dispatch.rs2   = rs2[4:0];
        @(negedge CLK);
        dispatch = '0;
    endtask

    task automatic do_writeback(input fu_e fu, input int rd, input logic [WORD_W-1:0] data);
        @(negedge CLK);
        wb.valid = 1'b1;
        wb.fu    = fu;
        wb.rd    = rd[4:0];
        wb.wdata = data;
        @(negedge CLK);
        wb = '0;
    endtask

    // Cycles until unit fu shows a packet, -1 when the limit runs out
    task automatic wait_issue(input fu_e fu, input int limit, output int cycles);
        cycles = 0;
        while (!(issue_out.valid === 1'b1 && issue_out.fu == fu) && cycles < limit) begin
            @(negedge CLK);
            cycles++;
        end
        if (!(issue_out.valid === 1'b1 && issue_out.fu == fu))
            cycles = -1;
    endtask

    task automatic check_latency(input fu_e fu, input int expected, input string what);
        int c;
        wait_issue(fu, 20, c);
        if (c < 0) begin
            $display("Timeout waiting for %s to issue", what);
            errors++;
        end else if (c != expected) begin
            $display("Fail issue latency of %s got %h expected %h", what, c, expected);
            errors++;
        end
    endtask

    task automatic expect_no_issue(input fu_e fu, input int cycles, input string what);
        int c;
        wait_issue(fu, cycles, c);
        if (c >= 0) begin
            $display("Unexpected issue of %s", what);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [WORD_W-1:0] got,
                              input logic [WORD_W-1:0] expected);
        if (got !== expected) begin
            $display("Fail %s got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    // Write back every EX row until the table is empty
    task automatic drain_rows();
        int n;
        n = 0;
        while (n < 200 && rows_busy()) begin
            @(negedge CLK);
            dispatch = '0;
            wb       = '0;
            for (int i = 0; i < NUM_FU; i++) begin
                if (!wb.valid && m_rows[i].state == EX)
                    wb = {1'b1, fu_e'(i), m_rows[i].rd, 32'($random(seed))};
            end
            n++;
        end
        @(negedge CLK);
        wb = '0;
        if (rows_busy()) begin
            $display("Timeout draining the status table");
            errors++;
        end
    endtask

    initial begin : main
        int f;
        int g;
        int c;
        seed       = 20249;
        errors     = 0;
        dut_issues = 0;
        exp_issues = 0;
        dispatch   = '0;
        wb         = '0;
        freeze     = 1'b0;
        nRST       = 1'b0;
        repeat (8) @(negedge CLK);
        nRST = 1'b1;

        // Independent instruction, operands from earlier writebacks
        do_writeback(ALU, 5, 32'h1111_0005);
        do_writeback(ALU, 6, 32'h2222_0006);
        do_writeback(ALU, 0, 32'hDEAD_0000);   // x0 keeps reading zero
        do_dispatch(ALU, 7, 5, 0);
        check_latency(ALU, 1, "independent ALU op");
        check_word("issue_out.rs1_data", issue_out.rs1_data, 32'h1111_0005);
        check_word("issue_out.rs2_data", issue_out.rs2_data, 32'h0);
        do_writeback(ALU, 7, 32'h3333_0007);

        // RAW on a load result
        do_dispatch(LD_ST, 8, 5, 6);
        check_latency(LD_ST, 1, "load");
        do_dispatch(ALU, 9, 8, 5);
        expect_no_issue(ALU, 6, "RAW consumer before writeback");
        do_writeback(LD_ST, 8, 32'hCAFE_0008);
        check_latency(ALU, 1, "RAW consumer");
        check_word("issue_out.rs1_data", issue_out.rs1_data, 32'hCAFE_0008);
        do_writeback(ALU, 9, 32'h0000_0009);

        // Two consumers woken by one writeback, older first
        do_dispatch(BRANCH, 10, 0, 0);
        check_latency(BRANCH, 1, "branch producer");
        do_dispatch(LD_ST, 11, 10, 0);   // Older one sits in the higher unit
        repeat (2) @(negedge CLK);
        do_dispatch(ALU, 12, 10, 5);
        do_writeback(BRANCH, 10, 32'hBEEF_000A);
        check_latency(LD_ST, 1, "older consumer");
        wait_issue(ALU, 5, c);
        if (c != 1) begin
            $display("Fail younger consumer latency got %h expected %h", c, 1);
            errors++;
        end
        do_writeback(LD_ST, 11, 32'h0000_000B);
        do_writeback(ALU, 12, 32'h0000_000C);

        // Dispatch to a busy unit is dropped
        do_dispatch(BRANCH, 14, 0, 0);
        check_latency(BRANCH, 1, "branch producer");
        do_dispatch(ALU, 13, 14, 0);
        do_dispatch(ALU, 15, 0, 0);
        check_word("dispatch_drop", 32'(dispatch_drop), 32'h1);
        do_writeback(BRANCH, 14, 32'h0000_000E);
        check_latency(ALU, 1, "waiting ALU op");
        check_word("issue_out.rd", 32'(issue_out.rd), 32'd13);
        do_writeback(ALU, 13, 32'h0000_000D);
        expect_no_issue(ALU, 5, "dropped ALU op");

        // Freeze holds a ready instruction
        @(negedge CLK);
        freeze = 1'b1;
        do_dispatch(ALU, 16, 5, 6);
        expect_no_issue(ALU, 6, "ALU op under freeze");
        @(negedge CLK);
        freeze = 1'b0;
        check_latency(ALU, 1, "ALU op after freeze");
        check_word("issue_out.rs1_data", issue_out.rs1_data, 32'h1111_0005);
        check_word("issue_out.rs2_data", issue_out.rs2_data, 32'h2222_0006);
        do_writeback(ALU, 16, 32'h0000_0010);

        // Random dispatches and writebacks, only to free units
        for (int n = 0; n < 400; n++) begin
            @(negedge CLK);
            dispatch = '0;
            wb       = '0;
            freeze   = (($random(seed) & 7) == 0);
            f = $unsigned($random(seed)) % NUM_FU;
            if (m_rows[f].state == EMPTY && ($random(seed) & 1))
                dispatch = {1'b1, fu_e'(f), 5'($random(seed)), 5'($random(seed)),
                            5'($random(seed))};
            g = $unsigned($random(seed)) % NUM_FU;
            if (m_rows[g].state == EX && ($random(seed) & 1))
                wb = {1'b1, fu_e'(g), m_rows[g].rd, 32'($random(seed))};
        end
        @(negedge CLK);
        freeze = 1'b0;
        drain_rows();
        repeat (4) @(negedge CLK);

        if (dut_issues != exp_issues) begin
            $display("Fail issue count got %h expected %h", dut_issues, exp_issues);
            errors++;
        end
        $display("Errors: %0d, issues seen %0d, issues expected %0d",
                 errors, dut_issues, exp_issues);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

//--- issue_stage.f
common/issue_pkg.sv
logic/regfile.sv
fust/fust_table.sv
logic/dispatch_ctrl.sv
issue/issue_select.sv
logic/issue_stage.sv
test/issue_stage_properties.sv
test/issue_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := issue_stage_tb
RTL_TOP   := issue_stage
FILELIST  := issue_stage.f
OBJ_DIR   := obj_dir
PASS_MSG  := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Passes only when the pass message appears in the output
run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
